// ==== src/hazardPkg.sv ====
package hazardPkg;

    typedef logic [4:0] regNumT;
    typedef logic [1:0] tCodeT;

    //////////////////////////////
    // Primary opcodes
    //////////////////////////////
    localparam logic [5:0] OP_RTYPE = 6'b000000;
    localparam logic [5:0] OP_ORI   = 6'b001101;
    localparam logic [5:0] OP_ADDI  = 6'b001000;
    localparam logic [5:0] OP_ANDI  = 6'b001100;
    localparam logic [5:0] OP_LUI   = 6'b001111;
    localparam logic [5:0] OP_LW    = 6'b100011;
    localparam logic [5:0] OP_LB    = 6'b100000;
    localparam logic [5:0] OP_LH    = 6'b100001;
    localparam logic [5:0] OP_SW    = 6'b101011;
    localparam logic [5:0] OP_SB    = 6'b101000;
    localparam logic [5:0] OP_SH    = 6'b101001;
    localparam logic [5:0] OP_BEQ   = 6'b000100;
    localparam logic [5:0] OP_BNE   = 6'b000101;
    localparam logic [5:0] OP_J     = 6'b000010;
    localparam logic [5:0] OP_JAL   = 6'b000011;

    //////////////////////////////
    // R-type function codes
    //////////////////////////////
    localparam logic [5:0] FN_ADD   = 6'b100000;
    localparam logic [5:0] FN_SUB   = 6'b100010;
    localparam logic [5:0] FN_AND   = 6'b100100;
    localparam logic [5:0] FN_OR    = 6'b100101;
    localparam logic [5:0] FN_SLT   = 6'b101010;
    localparam logic [5:0] FN_SLTU  = 6'b101011;
    localparam logic [5:0] FN_MULT  = 6'b011000;
    localparam logic [5:0] FN_MULTU = 6'b011001;
    localparam logic [5:0] FN_DIV   = 6'b011010;
    localparam logic [5:0] FN_DIVU  = 6'b011011;
    localparam logic [5:0] FN_MFHI  = 6'b010000;
    localparam logic [5:0] FN_MFLO  = 6'b010010;
    localparam logic [5:0] FN_MTHI  = 6'b010001;
    localparam logic [5:0] FN_MTLO  = 6'b010011;
    localparam logic [5:0] FN_JR    = 6'b001000;

    // Register zero never causes a hazard
    localparam regNumT REG_NONE = 5'd0;
    localparam regNumT REG_RA   = 5'd31;

    // Cycles until an operand is needed or a result is ready
    localparam tCodeT T_NOW = 2'd0;
    localparam tCodeT T_ONE = 2'd1;
    localparam tCodeT T_TWO = 2'd2;

    //////////////////////////////
    // Instruction word views
    //////////////////////////////
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            regNumT     rs;
            regNumT     rt;
            regNumT     rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } rView;
        struct packed {
            logic [5:0]  opcode;
            regNumT      rs;
            regNumT      rt;
            logic [15:0] imm;
        } iView;
    } instrT;

endpackage

// ==== src/operandUseIf.sv ====
`timescale 1ns/100ps

interface operandUseIf;
    import hazardPkg::*;

    regNumT useRs;
    regNumT useRt;
    tCodeT  tUseRs;
    tCodeT  tUseRt;

    modport producer (
        output useRs,
        output useRt,
        output tUseRs,
        output tUseRt
    );

    modport consumer (
        input useRs,
        input useRt,
        input tUseRs,
        input tUseRt
    );

endinterface

// ==== src/operandUseDecoder.sv ====
`timescale 1ns/100ps

module operandUseDecoder (
    input  hazardPkg::instrT instrD,
    operandUseIf.producer    opUse
);
    import hazardPkg::*;

    regNumT rsReg;
    regNumT rtReg;
    tCodeT  rsUse;
    tCodeT  rtUse;

    always_comb begin
        // Nops and unknown words read nothing
        rsReg = REG_NONE;
        rtReg = REG_NONE;
        rsUse = T_NOW;
        rtUse = T_NOW;

        case (instrD.rView.opcode)
            OP_RTYPE: begin
                case (instrD.rView.funct)
                    FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT, FN_SLTU,
                    FN_MULT, FN_MULTU, FN_DIV, FN_DIVU: begin
                        rsReg = instrD.rView.rs;
                        rtReg = instrD.rView.rt;
                        rsUse = T_ONE;
                        rtUse = T_ONE;
                    end
                    FN_MTHI, FN_MTLO: begin
                        rsReg = instrD.rView.rs;
                        rsUse = T_ONE;
                    end
                    // Jump target is needed in decode
                    FN_JR: begin
                        rsReg = instrD.rView.rs;
                        rsUse = T_NOW;
                    end
                    default: begin
                        rsReg = REG_NONE;
                    end
                endcase
            end
            OP_ORI, OP_ADDI, OP_ANDI, OP_LW, OP_LB, OP_LH: begin
                rsReg = instrD.rView.rs;
                rsUse = T_ONE;
            end
            // Store data is not needed until the memory stage
            OP_SW, OP_SB, OP_SH: begin
                rsReg = instrD.rView.rs;
                rtReg = instrD.rView.rt;
                rsUse = T_ONE;
                rtUse = T_TWO;
            end
            // Branch compare happens in decode
            OP_BEQ, OP_BNE: begin
                rsReg = instrD.rView.rs;
                rtReg = instrD.rView.rt;
                rsUse = T_NOW;
                rtUse = T_NOW;
            end
            default: begin
                rsReg = REG_NONE;
            end
        endcase
    end

    assign opUse.useRs  = rsReg;
    assign opUse.useRt  = rtReg;
    assign opUse.tUseRs = rsUse;
    assign opUse.tUseRt = rtUse;

endmodule

// ==== src/execNewDecoder.sv ====
`timescale 1ns/100ps

module execNewDecoder (
    input  hazardPkg::instrT  instrE,
    output hazardPkg::regNumT dstE,
    output hazardPkg::tCodeT  tNewE
);
    import hazardPkg::*;

    regNumT dstReg;
    tCodeT  newTime;

    always_comb begin
        dstReg  = REG_NONE;
        newTime = T_NOW;

        case (instrE.rView.opcode)
            OP_RTYPE: begin
                case (instrE.rView.funct)
                    FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT, FN_SLTU,
                    FN_MFHI, FN_MFLO: begin
                        dstReg  = instrE.rView.rd;
                        newTime = T_ONE;
                    end
                    default: begin
                        dstReg = REG_NONE;
                    end
                endcase
            end
            // Immediate ALU ops write rt
            OP_ORI, OP_ADDI, OP_ANDI, OP_LUI: begin
                dstReg  = instrE.iView.rt;
                newTime = T_ONE;
            end
            // Load data arrives after the memory stage
            OP_LW, OP_LB, OP_LH: begin
                dstReg  = instrE.iView.rt;
                newTime = T_TWO;
            end
            OP_JAL: begin
                dstReg  = REG_RA;
                newTime = T_NOW;
            end
            default: begin
                dstReg = REG_NONE;
            end
        endcase
    end

    assign dstE  = dstReg;
    assign tNewE = newTime;

endmodule

// ==== src/memNewTracker.sv ====
`timescale 1ns/100ps

module memNewTracker (
    input  logic              clk,
    input  logic              arstN,
    input  hazardPkg::regNumT dstE,
    input  hazardPkg::tCodeT  tNewE,
    output hazardPkg::regNumT dstM,
    output hazardPkg::tCodeT  tNewM
);
    import hazardPkg::*;

    tCodeT tNewAged;

    // One stage closer to ready, floor at zero
    assign tNewAged = (tNewE == T_NOW) ? T_NOW : tCodeT'(tNewE - T_ONE);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            dstM  <= REG_NONE;
            tNewM <= T_NOW;
        end else begin
            dstM  <= dstE;
            tNewM <= tNewAged;
        end
    end

endmodule

// ==== src/stallDetector.sv ====
`timescale 1ns/100ps

module stallDetector (
    input  hazardPkg::instrT  instrD,
    operandUseIf.consumer     opUse,
    input  hazardPkg::regNumT dstE,
    input  hazardPkg::regNumT dstM,
    input  hazardPkg::tCodeT  tNewE,
    input  hazardPkg::tCodeT  tNewM,
    input  logic              regWriteE,
    input  logic              regWriteM,
    input  logic              mduBusy,
    input  logic              mduStart,
    output logic              pcWrite,
    output logic              ifIdEn,
    output logic              idExClr,
    output logic              mduClr
);
    import hazardPkg::*;

    logic isRType;
    logic isHiLo;
    logic isMulDiv;
    logic mduActive;
    logic dataStall;
    logic stall;

    // Producer result would arrive after the operand is needed
    function automatic logic lateProducer(input regNumT useReg, input tCodeT tUse,
                                          input regNumT dst, input tCodeT tNew,
                                          input logic regWrite);
        lateProducer = (useReg != REG_NONE) && (useReg == dst) && regWrite && (tUse < tNew);
    endfunction

    assign isRType   = (instrD.rView.opcode == OP_RTYPE);
    assign isHiLo    = isRType && (instrD.rView.funct inside {FN_MFHI, FN_MFLO,
                                                              FN_MTHI, FN_MTLO});
    assign isMulDiv  = isRType && (instrD.rView.funct inside {FN_MULT, FN_MULTU,
                                                              FN_DIV, FN_DIVU});
    assign mduActive = mduBusy | mduStart;

    assign dataStall = lateProducer(opUse.useRs, opUse.tUseRs, dstE, tNewE, regWriteE)
                     | lateProducer(opUse.useRs, opUse.tUseRs, dstM, tNewM, regWriteM)
                     | lateProducer(opUse.useRt, opUse.tUseRt, dstE, tNewE, regWriteE)
                     | lateProducer(opUse.useRt, opUse.tUseRt, dstM, tNewM, regWriteM);

    assign stall = dataStall | (mduActive & isHiLo);

    //////////////////////////////
    // Pipeline controls
    //////////////////////////////
    assign pcWrite = ~stall;
    assign ifIdEn  = ~stall;
    assign idExClr = stall;

    // New multiply or divide restarts a busy unit
    assign mduClr  = mduActive & isMulDiv;

endmodule

// ==== src/hazardUnit.sv ====
`timescale 1ns/100ps

module hazardUnit (
    input  logic              clk,
    input  logic              arstN,
    input  hazardPkg::instrT  instrD,
    input  hazardPkg::instrT  instrE,
    input  logic              regWriteE,
    input  logic              regWriteM,
    input  logic              mduBusy,
    input  logic              mduStart,
    output logic              pcWrite,
    output logic              ifIdEn,
    output logic              idExClr,
    output logic              mduClr,
    output hazardPkg::regNumT useRsD,
    output hazardPkg::regNumT useRtD,
    output hazardPkg::tCodeT  tNewE,
    output hazardPkg::tCodeT  tNewM
);
    import hazardPkg::*;

    regNumT dstE;
    regNumT dstM;

    operandUseIf opUseBus ();

    //////////////////////////////
    // Decode stage consumers
    //////////////////////////////
    operandUseDecoder uOperandUse (
        .instrD (instrD),
        .opUse  (opUseBus.producer)
    );

    assign useRsD = opUseBus.useRs;
    assign useRtD = opUseBus.useRt;

    //////////////////////////////
    // Execute and memory producers
    //////////////////////////////
    execNewDecoder uExecNew (
        .instrE (instrE),
        .dstE   (dstE),
        .tNewE  (tNewE)
    );

    memNewTracker uMemNew (
        .clk    (clk),
        .arstN  (arstN),
        .dstE   (dstE),
        .tNewE  (tNewE),
        .dstM   (dstM),
        .tNewM  (tNewM)
    );

    stallDetector uStall (
        .instrD    (instrD),
        .opUse     (opUseBus.consumer),
        .dstE      (dstE),
        .dstM      (dstM),
        .tNewE     (tNewE),
        .tNewM     (tNewM),
        .regWriteE (regWriteE),
        .regWriteM (regWriteM),
        .mduBusy   (mduBusy),
        .mduStart  (mduStart),
        .pcWrite   (pcWrite),
        .ifIdEn    (ifIdEn),
        .idExClr   (idExClr),
        .mduClr    (mduClr)
    );

endmodule

// ==== tb/hazardChecker.sv ====
`timescale 1ns/100ps

module hazardChecker (
    input  logic              clk,
    input  logic              checkEn,
    input  int                rowIdx,
    input  logic [159:0]      rowName,
    input  logic              expPcWrite,
    input  logic              expMduClr,
    input  hazardPkg::regNumT expUseRs,
    input  hazardPkg::regNumT expUseRt,
    input  hazardPkg::tCodeT  expTNewE,
    input  hazardPkg::tCodeT  expTNewM,
    input  logic              pcWrite,
    input  logic              ifIdEn,
    input  logic              idExClr,
    input  logic              mduClr,
    input  hazardPkg::regNumT useRsD,
    input  hazardPkg::regNumT useRtD,
    input  hazardPkg::tCodeT  tNewE,
    input  hazardPkg::tCodeT  tNewM,
    output int                checkCount,
    output int                failCount
);
    import hazardPkg::*;

    int rowErrors;

    task automatic compareField(input string field, input int got, input int expected);
        if (got != expected) begin
            $display("[ERROR] time %0t: row %0d %s is %0d, expected %0d",
                     $time, rowIdx, field, got, expected);
            rowErrors++;
        end
    endtask

    initial begin
        checkCount = 0;
        failCount  = 0;
        forever begin
            @(negedge clk);
            // One ns before the rising edge
            #3;
            if (checkEn) begin
                rowErrors = 0;
                compareField("pcWrite", int'(pcWrite), int'(expPcWrite));
                compareField("ifIdEn", int'(ifIdEn), int'(expPcWrite));
                compareField("idExClr", int'(idExClr), int'(!expPcWrite));
                compareField("mduClr", int'(mduClr), int'(expMduClr));
                compareField("useRsD", int'(useRsD), int'(expUseRs));
                compareField("useRtD", int'(useRtD), int'(expUseRt));
                compareField("tNewE", int'(tNewE), int'(expTNewE));
                compareField("tNewM", int'(tNewM), int'(expTNewM));
                if (rowErrors == 0) begin
                    $display("ok   row %0d %s", rowIdx, rowName);
                end else begin
                    failCount++;
                    $display("bad  row %0d %s with %0d mismatches", rowIdx, rowName, rowErrors);
                end
                checkCount++;
            end
        end
    end

endmodule

// ==== tb/tbHazardUnit.sv ====
`timescale 1ns/100ps

module tbHazardUnit;
    import hazardPkg::*;

    localparam int CLK_PERIOD    = 8;
    localparam int RESET_CYCLES  = 16;
    localparam int RESET_TIMEOUT = 64;
    localparam int ROW_TIMEOUT   = 10;
    localparam logic [31:0] NOP  = 32'h0000_0000;

    typedef struct packed {
        logic [159:0] name;
        logic [31:0]  instrD;
        logic [31:0]  instrE;
        logic [3:0]   ctrl;
        logic         expPcWrite;
        logic         expMduClr;
        regNumT       expUseRs;
        regNumT       expUseRt;
        tCodeT        expTNewE;
        tCodeT        expTNewM;
    } rowT;

    logic         clk;
    logic         arstN;
    logic [31:0]  instrD;
    logic [31:0]  instrE;
    logic         regWriteE;
    logic         regWriteM;
    logic         mduBusy;
    logic         mduStart;
    logic         pcWrite;
    logic         ifIdEn;
    logic         idExClr;
    logic         mduClr;
    regNumT       useRsD;
    regNumT       useRtD;
    tCodeT        tNewE;
    tCodeT        tNewM;

    logic         checkEn;
    int           rowIdx;
    logic [159:0] rowName;
    logic         expPcWrite;
    logic         expMduClr;
    regNumT       expUseRs;
    regNumT       expUseRt;
    tCodeT        expTNewE;
    tCodeT        expTNewM;
    int           checkCount;
    int           failCount;

    rowT rows[$];

    function automatic logic [31:0] encodeR(input logic [5:0] funct, input regNumT rs,
                                            input regNumT rt, input regNumT rd);
        encodeR = {OP_RTYPE, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] encodeI(input logic [5:0] op, input regNumT rs,
                                            input regNumT rt, input logic [15:0] imm);
        encodeI = {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] encodeJ(input logic [5:0] op, input logic [25:0] target);
        encodeJ = {op, target};
    endfunction

    task automatic addRow(input logic [159:0] name, input logic [31:0] dWord,
                          input logic [31:0] eWord, input logic [3:0] ctrl,
                          input logic pcW, input logic mduC, input regNumT rs,
                          input regNumT rt, input tCodeT tE, input tCodeT tM);
        rowT r;
        r.name       = name;
        r.instrD     = dWord;
        r.instrE     = eWord;
        r.ctrl       = ctrl;
        r.expPcWrite = pcW;
        r.expMduClr  = mduC;
        r.expUseRs   = rs;
        r.expUseRt   = rt;
        r.expTNewE   = tE;
        r.expTNewM   = tM;
        rows.push_back(r);
    endtask

    //////////////////////////////
    // Stimulus table
    //////////////////////////////
    // ctrl is {regWriteE, regWriteM, mduBusy, mduStart}
    // then pcWrite, mduClr, useRsD, useRtD, tNewE, tNewM
    // tNewM comes from the execute word of the row before
    task automatic buildTable();
        addRow("reset clears mem", encodeR(FN_ADD, 5'd5, 5'd6, 5'd1), NOP,
               4'b0100, 1'b1, 1'b0, 5'd5, 5'd6, 2'd0, 2'd0);
        addRow("independent alu", encodeR(FN_ADD, 5'd1, 5'd2, 5'd3),
               encodeR(FN_SUB, 5'd8, 5'd9, 5'd7), 4'b1000, 1'b1, 1'b0, 5'd1, 5'd2, 2'd1, 2'd0);
        addRow("lui reads nothing", encodeI(OP_LUI, 5'd0, 5'd4, 16'h1234),
               encodeI(OP_ORI, 5'd11, 5'd10, 16'h00ff), 4'b1000, 1'b1, 1'b0, 5'd0, 5'd0, 2'd1, 2'd0);
        addRow("j reads nothing", encodeJ(OP_J, 26'h40), encodeJ(OP_JAL, 26'h80),
               4'b1000, 1'b1, 1'b0, 5'd0, 5'd0, 2'd0, 2'd0);
        addRow("lw-add stall", encodeR(FN_ADD, 5'd5, 5'd6, 5'd1),
               encodeI(OP_LW, 5'd2, 5'd5, 16'h4), 4'b1000, 1'b0, 1'b0, 5'd5, 5'd6, 2'd2, 2'd0);
        addRow("lw-add no regwrite", encodeR(FN_ADD, 5'd5, 5'd6, 5'd1),
               encodeI(OP_LW, 5'd2, 5'd5, 16'h4), 4'b0000, 1'b1, 1'b0, 5'd5, 5'd6, 2'd2, 2'd1);
        addRow("lh to r0", encodeR(FN_ADD, 5'd0, 5'd6, 5'd1),
               encodeI(OP_LH, 5'd3, 5'd0, 16'h2), 4'b1000, 1'b1, 1'b0, 5'd0, 5'd6, 2'd2, 2'd1);
        addRow("lw r5 in execute", encodeR(FN_OR, 5'd10, 5'd11, 5'd9),
               encodeI(OP_LW, 5'd2, 5'd5, 16'h8), 4'b1000, 1'b1, 1'b0, 5'd10, 5'd11, 2'd2, 2'd1);
        addRow("beq after lw in mem", encodeI(OP_BEQ, 5'd5, 5'd6, 16'h10), NOP,
               4'b0100, 1'b0, 1'b0, 5'd5, 5'd6, 2'd0, 2'd1);
        addRow("lw r5 again", NOP, encodeI(OP_LW, 5'd2, 5'd5, 16'h8),
               4'b1000, 1'b1, 1'b0, 5'd0, 5'd0, 2'd2, 2'd0);
        addRow("add after lw in mem", encodeR(FN_ADD, 5'd5, 5'd6, 5'd1), NOP,
               4'b0100, 1'b1, 1'b0, 5'd5, 5'd6, 2'd0, 2'd1);
        addRow("sw data after alu", encodeI(OP_SW, 5'd2, 5'd7, 16'h0),
               encodeR(FN_ADD, 5'd3, 5'd4, 5'd7), 4'b1000, 1'b1, 1'b0, 5'd2, 5'd7, 2'd1, 2'd0);
        addRow("sb base after lw", encodeI(OP_SB, 5'd8, 5'd9, 16'h1),
               encodeI(OP_LW, 5'd1, 5'd8, 16'h0), 4'b1000, 1'b0, 1'b0, 5'd8, 5'd9, 2'd2, 2'd0);
        addRow("sh data after lw", encodeI(OP_SH, 5'd1, 5'd8, 16'h2), NOP,
               4'b0100, 1'b1, 1'b0, 5'd1, 5'd8, 2'd0, 2'd1);
        addRow("mfhi mdu busy", encodeR(FN_MFHI, 5'd0, 5'd0, 5'd3), NOP,
               4'b0010, 1'b0, 1'b0, 5'd0, 5'd0, 2'd0, 2'd0);
        addRow("mflo mdu start", encodeR(FN_MFLO, 5'd0, 5'd0, 5'd4), NOP,
               4'b0001, 1'b0, 1'b0, 5'd0, 5'd0, 2'd0, 2'd0);
        addRow("mthi mdu busy", encodeR(FN_MTHI, 5'd6, 5'd0, 5'd0), NOP,
               4'b0010, 1'b0, 1'b0, 5'd6, 5'd0, 2'd0, 2'd0);
        addRow("mult clears busy", encodeR(FN_MULT, 5'd2, 5'd3, 5'd0), NOP,
               4'b0010, 1'b1, 1'b1, 5'd2, 5'd3, 2'd0, 2'd0);
        addRow("div clears start", encodeR(FN_DIV, 5'd4, 5'd5, 5'd0), NOP,
               4'b0001, 1'b1, 1'b1, 5'd4, 5'd5, 2'd0, 2'd0);
        addRow("mfhi idle", encodeR(FN_MFHI, 5'd0, 5'd0, 5'd3), NOP,
               4'b0000, 1'b1, 1'b0, 5'd0, 5'd0, 2'd0, 2'd0);
        addRow("multu idle", encodeR(FN_MULTU, 5'd2, 5'd3, 5'd0), NOP,
               4'b0000, 1'b1, 1'b0, 5'd2, 5'd3, 2'd0, 2'd0);
        addRow("jr after addi", encodeR(FN_JR, 5'd31, 5'd0, 5'd0),
               encodeI(OP_ADDI, 5'd0, 5'd31, 16'h10), 4'b1000, 1'b0, 1'b0, 5'd31, 5'd0, 2'd1, 2'd0);
        addRow("bne after jal", encodeI(OP_BNE, 5'd31, 5'd2, 16'h4), encodeJ(OP_JAL, 26'h80),
               4'b1100, 1'b1, 1'b0, 5'd31, 5'd2, 2'd0, 2'd0);
        addRow("mtlo mdu start", encodeR(FN_MTLO, 5'd7, 5'd0, 5'd0),
               encodeI(OP_ANDI, 5'd13, 5'd12, 16'h0f), 4'b1001, 1'b0, 1'b0, 5'd7, 5'd0, 2'd1, 2'd0);
    endtask

    hazardUnit i_dut (
        .clk       (clk),
        .arstN     (arstN),
        .instrD    (instrD),
        .instrE    (instrE),
        .regWriteE (regWriteE),
        .regWriteM (regWriteM),
        .mduBusy   (mduBusy),
        .mduStart  (mduStart),
        .pcWrite   (pcWrite),
        .ifIdEn    (ifIdEn),
        .idExClr   (idExClr),
        .mduClr    (mduClr),
        .useRsD    (useRsD),
        .useRtD    (useRtD),
        .tNewE     (tNewE),
        .tNewM     (tNewM)
    );

    hazardChecker uChecker (
        .clk        (clk),
        .checkEn    (checkEn),
        .rowIdx     (rowIdx),
        .rowName    (rowName),
        .expPcWrite (expPcWrite),
        .expMduClr  (expMduClr),
        .expUseRs   (expUseRs),
        .expUseRt   (expUseRt),
        .expTNewE   (expTNewE),
        .expTNewM   (expTNewM),
        .pcWrite    (pcWrite),
        .ifIdEn     (ifIdEn),
        .idExClr    (idExClr),
        .mduClr     (mduClr),
        .useRsD     (useRsD),
        .useRtD     (useRtD),
        .tNewE      (tNewE),
        .tNewM      (tNewM),
        .checkCount (checkCount),
        .failCount  (failCount)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        arstN = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        arstN = 1'b1;
    end

    //////////////////////////////
    // Main sequence
    //////////////////////////////
    initial begin
        int waited;
        int idx;
        instrD     = NOP;
        // Load to r5 held in execute while reset is asserted
        instrE     = encodeI(OP_LW, 5'd2, 5'd5, 16'h8);
        regWriteE  = 1'b1;
        regWriteM  = 1'b0;
        mduBusy    = 1'b0;
        mduStart   = 1'b0;
        checkEn    = 1'b0;
        rowIdx     = 0;
        rowName    = '0;
        expPcWrite = 1'b1;
        expMduClr  = 1'b0;
        expUseRs   = '0;
        expUseRt   = '0;
        expTNewE   = '0;
        expTNewM   = '0;
        buildTable();

        waited = 0;
        while (arstN !== 1'b1 && waited < RESET_TIMEOUT) begin
            @(negedge clk or posedge arstN);
            waited++;
        end
        if (arstN !== 1'b1) begin
            $display("Reset was still asserted after %0d cycles", waited);
            $display("** FAIL **");
            $finish;
        end

        for (idx = 0; idx < rows.size(); idx++) begin
            // First row goes in on the falling edge that releases reset
            if (idx > 0) begin
                @(negedge clk);
            end
            instrD     = rows[idx].instrD;
            instrE     = rows[idx].instrE;
            {regWriteE, regWriteM, mduBusy, mduStart} = rows[idx].ctrl;
            rowIdx     = idx;
            rowName    = rows[idx].name;
            expPcWrite = rows[idx].expPcWrite;
            expMduClr  = rows[idx].expMduClr;
            expUseRs   = rows[idx].expUseRs;
            expUseRt   = rows[idx].expUseRt;
            expTNewE   = rows[idx].expTNewE;
            expTNewM   = rows[idx].expTNewM;
            checkEn    = 1'b1;
            waited = 0;
            while (checkCount <= idx && waited < ROW_TIMEOUT) begin
                @(posedge clk);
                waited++;
            end
            if (checkCount <= idx) begin
                $display("Timeout: row %0d was not checked within %0d cycles", idx, ROW_TIMEOUT);
                $display("** FAIL **");
                $finish;
            end
        end

        checkEn = 1'b0;
        $display("Summary: %0d rows checked, %0d passed, %0d failed",
                 checkCount, checkCount - failCount, failCount);
        if (failCount == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
src/hazardPkg.sv
src/operandUseIf.sv
src/operandUseDecoder.sv
src/execNewDecoder.sv
src/memNewTracker.sv
src/stallDetector.sv
src/hazardUnit.sv
tb/hazardChecker.sv
tb/tbHazardUnit.sv

// ==== Makefile ====
SIM_LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f vlog.f --top-module tbHazardUnit -Mdir obj_dir -o simHazard
	./obj_dir/simHazard | tee $(SIM_LOG)
	grep -qF '** PASS **' $(SIM_LOG)

clean:
	rm -rf obj_dir $(SIM_LOG)
